// File: all.f
source/graph_pkg.sv
source/cu_bus_if.sv
source/job_fifo.sv
source/job_dispatch.sv
source/vertex_cu.sv
source/read_command_arbiter.sv
source/response_router.sv
source/graph_control_top.sv
tb/graph_control_tb.sv

// File: source/cu_bus_if.sv
`timescale 1ns/1ps

interface cu_bus_if;

	// job hand-off
	logic                                 job_request;
	logic                                 job_valid;
	logic [graph_pkg::VERTEX_ID_BITS-1:0] job_vertex_id;
	logic [graph_pkg::ADDR_BITS-1:0]      job_edge_base;
	logic [graph_pkg::EDGE_COUNT_BITS-1:0] job_edge_count;

	// read commands and their back-pressure
	logic                                 cmd_valid;
	logic [graph_pkg::ADDR_BITS-1:0]      cmd_address;
	logic [graph_pkg::CU_ID_BITS-1:0]     cmd_id_tag;
	logic                                 cmd_alfull;

	// returned responses
	logic                                 rsp_valid;
	logic [graph_pkg::ADDR_BITS-1:0]      rsp_address;

	modport cu (
		output job_request, cmd_valid, cmd_address, cmd_id_tag,
		input  job_valid, job_vertex_id, job_edge_base, job_edge_count,
		input  cmd_alfull, rsp_valid, rsp_address
	);

	modport dispatch (
		output job_valid, job_vertex_id, job_edge_base, job_edge_count,
		input  job_request
	);

	modport arbiter (output cmd_alfull, input cmd_valid, cmd_address, cmd_id_tag);

	modport router (output rsp_valid, rsp_address);

endinterface

// File: source/graph_control_top.sv
`timescale 1ns/1ps

module graph_control_top (
	input  logic                                  clock,
	input  logic                                  rstn,
	// upstream jobs
	input  logic                                  job_valid,
	input  logic [graph_pkg::VERTEX_ID_BITS-1:0]  job_vertex_id,
	input  logic [graph_pkg::ADDR_BITS-1:0]       job_edge_base,
	input  logic [graph_pkg::EDGE_COUNT_BITS-1:0] job_edge_count,
	output logic                                  job_request,
	// shared read port
	output logic                                  read_valid,
	output logic [graph_pkg::ADDR_BITS-1:0]       read_address,
	output logic [graph_pkg::CU_ID_BITS-1:0]      read_cu_id,
	input  logic                                  read_alfull,
	input  logic                                  response_valid,
	input  logic [graph_pkg::CU_ID_BITS-1:0]      response_cu_id,
	input  logic [graph_pkg::ADDR_BITS-1:0]       response_address,
	// completion counts
	output logic [graph_pkg::COUNTER_BITS-1:0]    vertex_count,
	output logic [graph_pkg::COUNTER_BITS-1:0]    edge_count
);

	cu_bus_if cu_bus [graph_pkg::NUM_CU] ();

	logic [graph_pkg::COUNTER_BITS-1:0] vertex_done [graph_pkg::NUM_CU];
	logic [graph_pkg::COUNTER_BITS-1:0] edge_done [graph_pkg::NUM_CU];
	logic [graph_pkg::COUNTER_BITS-1:0] vertex_sum;
	logic [graph_pkg::COUNTER_BITS-1:0] edge_sum;

	job_dispatch dispatch (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job_vertex_id (job_vertex_id),
		.job_edge_base (job_edge_base),
		.job_edge_count(job_edge_count),
		.job_request   (job_request),
		.cu_bus        (cu_bus)
	);

	for (genvar i = 0; i < graph_pkg::NUM_CU; i++) begin : g_cu
		vertex_cu #(
			.CU_ID(i)
		) cu (
			.clock            (clock),
			.rstn             (rstn),
			.cu_bus           (cu_bus[i]),
			.vertex_done_count(vertex_done[i]),
			.edge_done_count  (edge_done[i])
		);
	end

	read_command_arbiter arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.cu_bus      (cu_bus),
		.read_alfull (read_alfull),
		.read_valid  (read_valid),
		.read_address(read_address),
		.read_cu_id  (read_cu_id)
	);

	response_router router (
		.clock           (clock),
		.rstn            (rstn),
		.response_valid  (response_valid),
		.response_cu_id  (response_cu_id),
		.response_address(response_address),
		.cu_bus          (cu_bus)
	);

	////////////////////////////////////////
	// completion counts
	////////////////////////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int n = 0; n < graph_pkg::NUM_CU; n++) begin
			vertex_sum = vertex_sum + vertex_done[n];
			edge_sum   = edge_sum + edge_done[n];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			vertex_count <= vertex_sum;
			edge_count   <= edge_sum;
		end
	end

endmodule

// File: source/graph_pkg.sv
package graph_pkg;

	////////////////////////////////////////
	// sizes of the engine
	////////////////////////////////////////

	// peer compute units and the id that names one
	localparam int NUM_CU          = 4;
	localparam int CU_ID_BITS      = 2;

	// job fields
	localparam int VERTEX_ID_BITS  = 16;
	localparam int ADDR_BITS       = 32;
	localparam int EDGE_COUNT_BITS = 8;

	// byte stride between neighbouring edge entries
	localparam int EDGE_BYTES      = 4;

	// completion counters at the top level
	localparam int COUNTER_BITS    = 16;

	////////////////////////////////////////
	// buffering
	////////////////////////////////////////

	localparam int JOB_FIFO_DEPTH  = 16;
	localparam int CMD_FIFO_DEPTH  = 8;
	// free entries left when almost-full rises
	localparam int ALFULL_MARGIN   = 2;

	// packed job word is {vertex id, edge base, edge count}
	localparam int JOB_WIDTH = VERTEX_ID_BITS + ADDR_BITS + EDGE_COUNT_BITS;
	// packed command word is {cu id, address}
	localparam int CMD_WIDTH = CU_ID_BITS + ADDR_BITS;

	// first requester at or after ptr, wrapping around the units
	function automatic logic [CU_ID_BITS-1:0] rr_pick(input logic [NUM_CU-1:0] req,
			input logic [CU_ID_BITS-1:0] ptr);
		logic [CU_ID_BITS-1:0] pick;
		logic [CU_ID_BITS-1:0] cand;
		logic found;
		pick  = ptr;
		found = 1'b0;
		for (int n = 0; n < NUM_CU; n++) begin
			cand = ptr + n[CU_ID_BITS-1:0];
			if (!found && req[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
		end
		return pick;
	endfunction

endpackage

// File: source/job_dispatch.sv
`timescale 1ns/1ps

module job_dispatch (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  job_valid,
	input  logic [graph_pkg::VERTEX_ID_BITS-1:0]  job_vertex_id,
	input  logic [graph_pkg::ADDR_BITS-1:0]       job_edge_base,
	input  logic [graph_pkg::EDGE_COUNT_BITS-1:0] job_edge_count,
	output logic                                  job_request,
	cu_bus_if.dispatch                            cu_bus [graph_pkg::NUM_CU]
);

	logic [graph_pkg::JOB_WIDTH-1:0] head;
	logic [graph_pkg::JOB_WIDTH-1:0] job_q;
	logic job_empty;
	logic job_full;
	logic job_alfull;
	logic [graph_pkg::NUM_CU-1:0] idle;
	logic [graph_pkg::NUM_CU-1:0] grant_q;
	logic [graph_pkg::CU_ID_BITS-1:0] rr_ptr;
	logic [graph_pkg::CU_ID_BITS-1:0] grant_idx;
	logic pop;

	job_fifo #(
		.WIDTH(graph_pkg::JOB_WIDTH),
		.DEPTH(graph_pkg::JOB_FIFO_DEPTH)
	) vertex_job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid),
		.data_in ({job_vertex_id, job_edge_base, job_edge_count}),
		.pop     (pop),
		.data_out(head),
		.empty   (job_empty),
		.full    (job_full),
		.alfull  (job_alfull)
	);

	////////////////////////////////////////
	// grant to idle units
	////////////////////////////////////////

	// a unit granted last cycle still shows its request this cycle
	for (genvar i = 0; i < graph_pkg::NUM_CU; i++) begin : g_unit
		assign idle[i] = cu_bus[i].job_request && !grant_q[i];
		assign cu_bus[i].job_valid      = grant_q[i];
		assign cu_bus[i].job_vertex_id  = job_q[graph_pkg::JOB_WIDTH-1 -: graph_pkg::VERTEX_ID_BITS];
		assign cu_bus[i].job_edge_base  = job_q[graph_pkg::EDGE_COUNT_BITS +: graph_pkg::ADDR_BITS];
		assign cu_bus[i].job_edge_count = job_q[graph_pkg::EDGE_COUNT_BITS-1:0];
	end

	assign pop       = !job_empty && (|idle);
	assign grant_idx = graph_pkg::rr_pick(idle, rr_ptr);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q     <= '0;
			rr_ptr      <= '0;
			job_request <= 1'b0;
		end else begin
			grant_q     <= '0;
			job_request <= !job_alfull;
			if (pop) begin
				grant_q[grant_idx] <= 1'b1;
				rr_ptr             <= grant_idx + 1'b1;
			end
		end
	end

	// one job register shared by all units, only the granted one sees valid
	always_ff @(posedge clock) begin
		if (pop)
			job_q <= head;
	end

	// upstream must stop once job_request falls
	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		job_valid |-> !job_full)
		else $error("job pushed into a full job buffer");

endmodule

// File: source/job_fifo.sv
`timescale 1ns/1ps

module job_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;
	logic do_push;
	logic do_pop;

	// overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// head word is visible without a pop
	assign data_out = mem[rd_ptr];
	assign empty    = (count == 0);
	assign full     = (count == DEPTH);
	assign alfull   = (count >= DEPTH - graph_pkg::ALFULL_MARGIN);

endmodule

// File: source/read_command_arbiter.sv
`timescale 1ns/1ps

module read_command_arbiter (
	input  logic                             clock,
	input  logic                             rstn,
	cu_bus_if.arbiter                        cu_bus [graph_pkg::NUM_CU],
	input  logic                             read_alfull,
	output logic                             read_valid,
	output logic [graph_pkg::ADDR_BITS-1:0]  read_address,
	output logic [graph_pkg::CU_ID_BITS-1:0] read_cu_id
);

	logic [graph_pkg::CMD_WIDTH-1:0] buf_data [graph_pkg::NUM_CU];
	logic [graph_pkg::NUM_CU-1:0] buf_push;
	logic [graph_pkg::NUM_CU-1:0] buf_pop;
	logic [graph_pkg::NUM_CU-1:0] buf_empty;
	logic [graph_pkg::NUM_CU-1:0] buf_full;
	logic [graph_pkg::CU_ID_BITS-1:0] rr_ptr;
	logic [graph_pkg::CU_ID_BITS-1:0] grant_idx;
	logic pop;

	////////////////////////////////////////
	// per-unit command buffers
	////////////////////////////////////////

	for (genvar i = 0; i < graph_pkg::NUM_CU; i++) begin : g_cmd
		assign buf_push[i] = cu_bus[i].cmd_valid;
		assign buf_pop[i]  = pop && (grant_idx == i);

		job_fifo #(
			.WIDTH(graph_pkg::CMD_WIDTH),
			.DEPTH(graph_pkg::CMD_FIFO_DEPTH)
		) cmd_buffer (
			.clock   (clock),
			.rstn    (rstn),
			.push    (buf_push[i]),
			.data_in ({cu_bus[i].cmd_id_tag, cu_bus[i].cmd_address}),
			.pop     (buf_pop[i]),
			.data_out(buf_data[i]),
			.empty   (buf_empty[i]),
			.full    (buf_full[i]),
			.alfull  (cu_bus[i].cmd_alfull)
		);

		// the unit has to honour cmd_alfull in time
		no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
			buf_push[i] |-> !buf_full[i])
			else $error("command pushed into full buffer of unit %0d", i);
	end

	////////////////////////////////////////
	// merge onto the read port
	////////////////////////////////////////

	assign pop       = !read_alfull && !(&buf_empty);
	assign grant_idx = graph_pkg::rr_pick(~buf_empty, rr_ptr);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_valid <= 1'b0;
			rr_ptr     <= '0;
		end else begin
			read_valid <= pop;
			if (pop)
				rr_ptr <= grant_idx + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (pop)
			{read_cu_id, read_address} <= buf_data[grant_idx];
	end

endmodule

// File: source/response_router.sv
`timescale 1ns/1ps

module response_router (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             response_valid,
	input  logic [graph_pkg::CU_ID_BITS-1:0] response_cu_id,
	input  logic [graph_pkg::ADDR_BITS-1:0]  response_address,
	cu_bus_if.router                         cu_bus [graph_pkg::NUM_CU]
);

	logic [graph_pkg::NUM_CU-1:0] rsp_q;
	logic [graph_pkg::ADDR_BITS-1:0] address_q;

	// registered one-hot decode of the id
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_q <= '0;
		end else begin
			rsp_q <= '0;
			if (response_valid)
				rsp_q[response_cu_id] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (response_valid)
			address_q <= response_address;
	end

	for (genvar i = 0; i < graph_pkg::NUM_CU; i++) begin : g_unit
		assign cu_bus[i].rsp_valid   = rsp_q[i];
		assign cu_bus[i].rsp_address = address_q;
	end

	// memory must echo an id that a unit actually issued
	valid_cu_id: assert property (@(posedge clock) disable iff (!rstn)
		response_valid |-> !$isunknown(response_cu_id) &&
			(response_cu_id < graph_pkg::NUM_CU))
		else $error("response carries unknown unit id %0d", response_cu_id);

endmodule

// File: source/vertex_cu.sv
`timescale 1ns/1ps

module vertex_cu #(
	parameter int CU_ID = 0
) (
	input  logic                               clock,
	input  logic                               rstn,
	cu_bus_if.cu                               cu_bus,
	output logic [graph_pkg::COUNTER_BITS-1:0] vertex_done_count,
	output logic [graph_pkg::COUNTER_BITS-1:0] edge_done_count
);

	logic busy;
	logic [graph_pkg::VERTEX_ID_BITS-1:0] vertex_id_q;
	logic [graph_pkg::EDGE_COUNT_BITS-1:0] edge_count_q;
	logic [graph_pkg::EDGE_COUNT_BITS-1:0] issued_q;
	logic [graph_pkg::EDGE_COUNT_BITS-1:0] returned_q;
	logic [graph_pkg::ADDR_BITS-1:0] next_addr;
	logic issue;
	logic last_rsp;

	////////////////////////////////////////
	// command issue
	////////////////////////////////////////

	// one edge per cycle until all are out or the buffer pushes back
	assign issue = busy && (issued_q != edge_count_q) && !cu_bus.cmd_alfull;

	assign cu_bus.cmd_valid   = issue;
	assign cu_bus.cmd_address = next_addr;
	assign cu_bus.cmd_id_tag  = CU_ID[graph_pkg::CU_ID_BITS-1:0];

	// job done once this response brings the returned count up to the edge count
	assign last_rsp = busy && cu_bus.rsp_valid && (returned_q + 1'b1 == edge_count_q);

	////////////////////////////////////////
	// job state and counters
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy              <= 1'b0;
			cu_bus.job_request <= 1'b0;
			issued_q          <= '0;
			returned_q        <= '0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else if (!busy) begin
			cu_bus.job_request <= 1'b1;
			if (cu_bus.job_valid) begin
				issued_q   <= '0;
				returned_q <= '0;
				if (cu_bus.job_edge_count == 0) begin
					// nothing to fetch so the job retires at once
					vertex_done_count <= vertex_done_count + 1'b1;
				end else begin
					busy               <= 1'b1;
					cu_bus.job_request <= 1'b0;
				end
			end
		end else begin
			if (issue)
				issued_q <= issued_q + 1'b1;
			if (cu_bus.rsp_valid)
				returned_q <= returned_q + 1'b1;
			if (last_rsp) begin
				busy               <= 1'b0;
				cu_bus.job_request <= 1'b1;
				vertex_done_count  <= vertex_done_count + 1'b1;
				edge_done_count    <= edge_done_count +
					{{(graph_pkg::COUNTER_BITS - graph_pkg::EDGE_COUNT_BITS){1'b0}}, edge_count_q};
			end
		end
	end

	// job payload and address walk
	always_ff @(posedge clock) begin
		if (!busy && cu_bus.job_valid) begin
			vertex_id_q  <= cu_bus.job_vertex_id;
			edge_count_q <= cu_bus.job_edge_count;
			next_addr    <= cu_bus.job_edge_base;
		end else if (issue) begin
			next_addr <= next_addr + graph_pkg::EDGE_BYTES;
		end
	end

	// responses only come back for commands of the current job
	rsp_only_when_busy: assert property (@(posedge clock) disable iff (!rstn)
		cu_bus.rsp_valid |-> busy)
		else $error("unit %0d got a response while idle, last vertex %0h",
			CU_ID, vertex_id_q);

	// returned address lies among the edges issued so far for this job
	rsp_in_issued_range: assert property (@(posedge clock) disable iff (!rstn)
		cu_bus.rsp_valid && busy |->
			(cu_bus.rsp_address < next_addr) &&
			(cu_bus.rsp_address >= next_addr - issued_q * graph_pkg::EDGE_BYTES))
		else $error("unit %0d got response address %0h outside its job",
			CU_ID, cu_bus.rsp_address);

endmodule

// File: tb/graph_control_tb.sv
`timescale 1ns/1ps

module graph_control_tb;

	localparam int NUM_JOBS   = 60;
	// jobs at the front all carry edges so that a busy unit keeps its job
	localparam int BUSY_JOBS  = 24;
	// each unit holds one job on top of the full buffer
	localparam int HOLD_BOUND = graph_pkg::JOB_FIFO_DEPTH + graph_pkg::NUM_CU;

	logic        clock;
	logic        rstn;
	logic        job_valid;
	logic [15:0] job_vertex_id;
	logic [31:0] job_edge_base;
	logic [7:0]  job_edge_count;
	logic        job_request;
	logic        read_valid;
	logic [31:0] read_address;
	logic [1:0]  read_cu_id;
	logic        read_alfull;
	logic        response_valid;
	logic [1:0]  response_cu_id;
	logic [31:0] response_address;
	logic [15:0] vertex_count;
	logic [15:0] edge_count;

	// job list, generated up front
	logic [15:0] job_vid [NUM_JOBS];
	logic [31:0] job_base [NUM_JOBS];
	logic [7:0]  job_edges [NUM_JOBS];
	int next_job;
	int total_edges;

	// expected read addresses, as a multiset
	int exp_count [bit [31:0]];
	int read_total;

	// job of each expected address and the unit seen serving each job
	int addr_job [bit [31:0]];
	int job_unit [NUM_JOBS];
	int read_job;

	// memory responder queue
	logic [31:0] pend_addr [$];
	logic [1:0]  pend_id [$];
	int          pend_due [$];

	logic hold_alfull;
	int   burst_left;
	logic alfull_prev;
	int   cycle;
	int   cycle_limit;

	int errs_hold;
	int errs_cmd;
	int errs_gap;
	int errs_done;
	int tests_passed;
	int tests_failed;
	int pushed;

	graph_control_top uut (
		.clock           (clock),
		.rstn            (rstn),
		.job_valid       (job_valid),
		.job_vertex_id   (job_vertex_id),
		.job_edge_base   (job_edge_base),
		.job_edge_count  (job_edge_count),
		.job_request     (job_request),
		.read_valid      (read_valid),
		.read_address    (read_address),
		.read_cu_id      (read_cu_id),
		.read_alfull     (read_alfull),
		.response_valid  (response_valid),
		.response_cu_id  (response_cu_id),
		.response_address(response_address),
		.vertex_count    (vertex_count),
		.edge_count      (edge_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////
	// memory side
	////////////////////////////////////////

	// back-pressure in random bursts, or held high on request
	always @(posedge clock) begin
		if (hold_alfull) begin
			read_alfull <= 1'b1;
		end else if (burst_left > 0) begin
			read_alfull <= 1'b1;
			burst_left = burst_left - 1;
		end else if ($urandom_range(0, 9) == 0) begin
			read_alfull <= 1'b1;
			burst_left = $urandom_range(0, 5);
		end else begin
			read_alfull <= 1'b0;
		end
	end

	// responses come back in order after a random delay
	always @(posedge clock) begin
		if (!rstn) begin
			response_valid <= 1'b0;
		end else begin
			if (read_valid) begin
				pend_addr.push_back(read_address);
				pend_id.push_back(read_cu_id);
				pend_due.push_back(cycle + 2 + $urandom_range(0, 10));
			end
			if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
				response_valid   <= 1'b1;
				response_cu_id   <= pend_id.pop_front();
				response_address <= pend_addr.pop_front();
				void'(pend_due.pop_front());
			end else begin
				response_valid <= 1'b0;
			end
		end
	end

	// read commands against the expected set, and the gap after back-pressure
	always @(posedge clock) begin
		if (rstn) begin
			if (read_valid) begin
				read_total = read_total + 1;
				if (exp_count.exists(read_address)) begin
					// all edges of one job come from the unit that holds it
					read_job = addr_job[read_address];
					if (job_unit[read_job] < 0) begin
						job_unit[read_job] = read_cu_id;
					end else if (job_unit[read_job] != read_cu_id) begin
						$display("Error read_commands: job %0d expected unit %0d, actual %0d",
							read_job, job_unit[read_job], read_cu_id);
						errs_cmd = errs_cmd + 1;
					end
					exp_count[read_address] = exp_count[read_address] - 1;
					if (exp_count[read_address] == 0)
						exp_count.delete(read_address);
				end else begin
					$display("read_commands: address %h was not expected or was read twice",
						read_address);
					errs_cmd = errs_cmd + 1;
				end
			end
			if (alfull_prev && read_valid) begin
				$display("alfull_gap: read_valid high in the cycle after read_alfull at %0t",
					$time);
				errs_gap = errs_gap + 1;
			end
		end
		alfull_prev = read_alfull;
	end

	////////////////////////////////////////
	// upstream jobs
	////////////////////////////////////////

	task automatic feed_jobs(input int limit, input bit stop_on_low, output int count);
		bit done;
		done  = 1'b0;
		count = 0;
		while (!done) begin
			@(posedge clock);
			if (job_request && count < limit && next_job < NUM_JOBS) begin
				job_valid      <= 1'b1;
				job_vertex_id  <= job_vid[next_job];
				job_edge_base  <= job_base[next_job];
				job_edge_count <= job_edges[next_job];
				for (int e = 0; e < job_edges[next_job]; e++) begin
					if (exp_count.exists(job_base[next_job] + e * 4))
						exp_count[job_base[next_job] + e * 4] += 1;
					else
						exp_count[job_base[next_job] + e * 4] = 1;
					addr_job[job_base[next_job] + e * 4] = next_job;
				end
				next_job = next_job + 1;
				count    = count + 1;
			end else begin
				job_valid <= 1'b0;
				if (stop_on_low || count >= limit || next_job >= NUM_JOBS)
					done = 1'b1;
			end
		end
	endtask

	task automatic report(input string name, input int errs);
		if (errs == 0) begin
			$display("test %-14s ok", name);
			tests_passed = tests_passed + 1;
		end else begin
			$display("test %-14s failed with %0d errors", name, errs);
			tests_failed = tests_failed + 1;
		end
	endtask

	initial begin
		void'($urandom(32'h52e9_3799));
		rstn             = 1'b0;
		job_valid        = 1'b0;
		job_vertex_id    = '0;
		job_edge_base    = '0;
		job_edge_count   = '0;
		read_alfull      = 1'b0;
		response_valid   = 1'b0;
		response_cu_id   = '0;
		response_address = '0;
		hold_alfull      = 1'b1;
		burst_left       = 0;
		alfull_prev      = 1'b0;
		cycle            = 0;
		next_job         = 0;
		total_edges      = 0;
		read_total       = 0;

		// 64 bytes per job keeps every edge address unique
		for (int j = 0; j < NUM_JOBS; j++) begin
			job_vid[j]   = $urandom();
			job_base[j]  = 32'h0010_0000 + j * 64 + $urandom_range(0, 3) * 4;
			// every eighth later job carries no edges
			if (j < BUSY_JOBS)
				job_edges[j] = $urandom_range(1, 12);
			else if (j % 8 == 0)
				job_edges[j] = 0;
			else
				job_edges[j] = $urandom_range(0, 12);
			job_unit[j]  = -1;
			total_edges  = total_edges + job_edges[j];
		end
		cycle_limit = 400 + 30 * total_edges;

		repeat (2) @(posedge clock);
		rstn <= 1'b1;

		// buffer fills while memory stalls
		while (!job_request)
			@(posedge clock);
		feed_jobs(HOLD_BOUND + 1, 1'b1, pushed);
		if (pushed > HOLD_BOUND) begin
			$display("Error alfull_hold: expected at most %0d pushes, actual %0d",
				HOLD_BOUND, pushed);
			errs_hold = errs_hold + 1;
		end
		report("alfull_hold", errs_hold);
		hold_alfull <= 1'b0;

		feed_jobs(NUM_JOBS, 1'b0, pushed);

		// retirement shows up on vertex_count
		while (vertex_count != NUM_JOBS)
			@(posedge clock);
		repeat (20) @(posedge clock);

		if (read_total != total_edges) begin
			$display("Error read_commands: expected %0d commands, actual %0d",
				total_edges, read_total);
			errs_cmd = errs_cmd + 1;
		end
		if (exp_count.size() != 0) begin
			$display("read_commands: %0d expected addresses were never read", exp_count.size());
			errs_cmd = errs_cmd + 1;
		end
		report("read_commands", errs_cmd);
		report("alfull_gap", errs_gap);

		if (vertex_count != NUM_JOBS) begin
			$display("Error completion: vertex_count expected %0d, actual %0d",
				NUM_JOBS, vertex_count);
			errs_done = errs_done + 1;
		end
		if (edge_count != total_edges) begin
			$display("Error completion: edge_count expected %0d, actual %0d",
				total_edges, edge_count);
			errs_done = errs_done + 1;
		end
		report("completion", errs_done);

		$display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
